// File: files.f
apb_mon_pkg.sv
apb_mon_if.sv
apb_capture_stage.sv
apb_rule_stage.sv
apb_report_queue.sv
apb_monitor_top.sv
apb_monitor_sva.sv
tb_apb_monitor.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the APB4 monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_apb_monitor \
  -f files.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

# The log decides the result
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "simulation did not pass"; exit 1; }
exit 0

// File: tb_apb_monitor.sv
/*
 * Testbench for the APB4 protocol monitor
 *  - clock, reset, legal and faulty APB4 transfers
 *  - expected-report queue, credit-returning logger model
 *  - run time limit and closing summary
 */
`timescale 1ns/1ns

module tb_apb_monitor;
  import apb_mon_pkg::*;

  localparam int NUM_TESTS = 10;

  logic                         PCLK;
  logic                         PRESETn;
  logic                         psel;
  logic                         penable;
  logic [ADDR_WIDTH-1:0]        paddr;
  logic                         pwrite;
  logic [DATA_WIDTH-1:0]        pwdata;
  logic [STRB_WIDTH-1:0]        pstrb;
  logic [PROT_WIDTH-1:0]        pprot;
  logic                         pready;
  logic                         report_credit;
  logic                         report_valid;
  logic [RULE_ID_WIDTH-1:0]     report_rule;
  logic [PAYLOAD_WIDTH-1:0]     report_payload;
  rule_vec_t                    violation_flags;
  logic [DROP_COUNT_WIDTH-1:0]  drop_count;

  // Expected reports, oldest first
  logic [RULE_ID_WIDTH-1:0]     exp_rule_q[$];
  logic [PAYLOAD_WIDTH-1:0]     exp_payload_q[$];
  logic [RULE_ID_WIDTH-1:0]     exp_rule;
  logic [PAYLOAD_WIDTH-1:0]     exp_payload;
  logic [DATA_WIDTH-1:0]        cur_data;
  int                           errors;
  int                           tests_run;
  int                           tests_failed;
  int                           test_err_start;
  // Credits owed back to the monitor
  int                           owed;
  bit                           withhold;

  apb_monitor_top apb_monitor_top_i (
    .PCLK            (PCLK),
    .PRESETn         (PRESETn),
    .psel            (psel),
    .penable         (penable),
    .paddr           (paddr),
    .pwrite          (pwrite),
    .pwdata          (pwdata),
    .pstrb           (pstrb),
    .pprot           (pprot),
    .pready          (pready),
    .report_credit   (report_credit),
    .report_valid    (report_valid),
    .report_rule     (report_rule),
    .report_payload  (report_payload),
    .violation_flags (violation_flags),
    .drop_count      (drop_count)
  );

  initial
  begin
    PCLK = 1'b0;
    forever #2 PCLK = ~PCLK;
  end

  ////////////////////////////////////////////////////////////
  // Bus driving
  ////////////////////////////////////////////////////////////
  // One bus cycle, driven just after the rising edge
  task automatic bus_cycle(input logic sel, input logic en, input logic [ADDR_WIDTH-1:0] addr,
                           input logic wr, input logic [STRB_WIDTH-1:0] strb,
                           input logic rdy);
    @(posedge PCLK);
    #1;
    psel    = sel;
    penable = en;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = cur_data;
    pstrb   = strb;
    pprot   = 3'b010;
    pready  = rdy;
  endtask

  // Setup, wait states, completing Access, then one idle cycle
  task automatic run_transfer(input logic [ADDR_WIDTH-1:0] addr, input logic wr,
                              input logic [STRB_WIDTH-1:0] strb, input int waits);
    cur_data = $urandom;
    bus_cycle(1'b1, 1'b0, addr, wr, strb, 1'b0);
    for (int i = 0; i < waits; i++)
      bus_cycle(1'b1, 1'b1, addr, wr, strb, 1'b0);
    bus_cycle(1'b1, 1'b1, addr, wr, strb, 1'b1);
    bus_cycle(1'b0, 1'b0, addr, wr, strb, 1'b0);
  endtask

  // Random byte, half-word or word strobe, naturally aligned
  function automatic logic [STRB_WIDTH-1:0] legal_strobe();
    logic [STRB_WIDTH-1:0] shapes [7];
    shapes = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
    return shapes[$urandom % 7];
  endfunction

  // PSEL falls while the Access still waits
  task automatic drop_psel(input logic [ADDR_WIDTH-1:0] addr);
    bus_cycle(1'b1, 1'b0, addr, 1'b1, 4'hf, 1'b0);
    bus_cycle(1'b1, 1'b1, addr, 1'b1, 4'hf, 1'b0);
    bus_cycle(1'b0, 1'b0, addr, 1'b1, 4'hf, 1'b0);
  endtask

  task automatic penable_in_setup(input logic [ADDR_WIDTH-1:0] addr);
    bus_cycle(1'b1, 1'b1, addr, 1'b0, 4'h0, 1'b0);
    bus_cycle(1'b1, 1'b1, addr, 1'b0, 4'h0, 1'b1);
    bus_cycle(1'b0, 1'b0, addr, 1'b0, 4'h0, 1'b0);
  endtask

  // Address moves in the completing cycle after a wait
  task automatic move_paddr(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [ADDR_WIDTH-1:0] moved);
    bus_cycle(1'b1, 1'b0, addr, 1'b0, 4'h0, 1'b0);
    bus_cycle(1'b1, 1'b1, addr, 1'b0, 4'h0, 1'b0);
    bus_cycle(1'b1, 1'b1, moved, 1'b0, 4'h0, 1'b1);
    bus_cycle(1'b0, 1'b0, moved, 1'b0, 4'h0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////
  task automatic expect_report(input int rule, input logic [PAYLOAD_WIDTH-1:0] payload);
    exp_rule_q.push_back(RULE_ID_WIDTH'(rule));
    exp_payload_q.push_back(payload);
  endtask

  // Waits for all expected reports, then watches for extra ones
  task automatic wait_drain;
    int n;
    n = 0;
    while (exp_rule_q.size() != 0 && n < 300)
    begin
      @(posedge PCLK);
      n++;
    end
    assert (exp_rule_q.size() == 0) else
    begin
      errors++;
      $display("expected report did not arrive within 300 cycles");
    end
    repeat (8) @(posedge PCLK);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_err_start)
      tests_failed++;
    $display("test %s: %s", name, (errors != test_err_start) ? "failed" : "ok");
    test_err_start = errors;
  endtask

  // Report compare, sampled away from the clock edge
  initial
  begin
    forever
    begin
      @(negedge PCLK);
      if (PRESETn && report_valid)
      begin
        owed++;
        assert (exp_rule_q.size() != 0) else
        begin
          errors++;
          $display("unexpected report with rule %0d, payload %h", report_rule, report_payload);
        end
        if (exp_rule_q.size() != 0)
        begin
          exp_rule    = exp_rule_q.pop_front();
          exp_payload = exp_payload_q.pop_front();
          assert (report_rule == exp_rule) else
          begin
            errors++;
            $display("MISMATCH report_rule: expected %h, got %h", exp_rule, report_rule);
          end
          assert (report_payload == exp_payload) else
          begin
            errors++;
            $display("MISMATCH report_payload: expected %h, got %h",
                     exp_payload, report_payload);
          end
          assert (violation_flags[exp_rule]) else
          begin
            errors++;
            $display("MISMATCH violation_flags: bit %0d not set, got %h",
                     exp_rule, violation_flags);
          end
        end
      end
    end
  end

  // Logger model, credits return after a random delay
  initial
  begin
    report_credit = 1'b0;
    forever
    begin
      @(posedge PCLK);
      #1;
      report_credit = 1'b0;
      if (!withhold && owed > 0 && ($urandom % 3) == 0)
      begin
        report_credit = 1'b1;
        owed--;
      end
    end
  end

  // Run time limit
  initial
  begin
    #(NUM_TESTS * 400 * 4);
    $display("timeout: the run did not complete in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    logic [ADDR_WIDTH-1:0]       addr;
    logic [DROP_COUNT_WIDTH-1:0] drop_before;
    logic                        wr;
    void'($urandom(18963));
    PRESETn  = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    paddr    = '0;
    pwrite   = 1'b0;
    pwdata   = '0;
    pstrb    = '0;
    pprot    = '0;
    pready   = 1'b0;
    cur_data = '0;
    errors   = 0;
    owed     = 0;
    withhold = 1'b0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err_start = 0;
    repeat (16) @(posedge PCLK);
    #1;
    PRESETn = 1'b1;

    // Legal traffic must stay silent
    for (int i = 0; i < 8; i++)
    begin
      wr = 1'($urandom % 2);
      run_transfer($urandom & 32'hffff_fffc, wr, wr ? legal_strobe() : 4'h0,
                   int'($urandom % 4));
    end
    wait_drain();
    assert (violation_flags == '0) else
    begin
      errors++;
      $display("MISMATCH violation_flags: expected 0000, got %h", violation_flags);
    end
    assert (drop_count == '0) else
    begin
      errors++;
      $display("MISMATCH drop_count: expected 00, got %h", drop_count);
    end
    finish_test("legal transfers");

    addr = 32'h0000_1000;
    expect_report(RULE_PSEL_DROP, addr);
    drop_psel(addr);
    wait_drain();
    finish_test("psel drop");

    addr = 32'h0000_2010;
    expect_report(RULE_PENABLE_SETUP, addr);
    penable_in_setup(addr);
    wait_drain();
    finish_test("penable in setup");

    expect_report(RULE_PADDR_UNSTABLE, 32'h0000_3044);
    move_paddr(32'h0000_3040, 32'h0000_3044);
    wait_drain();
    finish_test("paddr unstable");

    addr = 32'h0000_4000;
    expect_report(RULE_PSTRB_SHAPE, addr);
    run_transfer(addr, 1'b1, 4'b0101, 1);
    wait_drain();
    finish_test("strobe shape");

    addr = 32'h0000_5008;
    expect_report(RULE_PSTRB_READ, addr);
    run_transfer(addr, 1'b0, 4'hf, 0);
    wait_drain();
    finish_test("strobe on read");

    // Offset 1 also breaks word alignment, rule 10 wins
    addr = 32'h0000_6001;
    expect_report(RULE_PADDR_STRB_ALIGN, addr);
    run_transfer(addr, 1'b1, 4'b1100, 0);
    wait_drain();
    finish_test("strobe alignment");

    addr = 32'h0000_7002;
    expect_report(RULE_PADDR_WORD_ALIGN, addr);
    run_transfer(addr, 1'b0, 4'h0, 1);
    wait_drain();
    finish_test("word alignment");

    // Setup plus 15 waits reaches the limit once
    expect_report(RULE_WATCHDOG, PAYLOAD_WIDTH'(WATCHDOG_LIMIT));
    run_transfer(32'h0000_8000, 1'b1, 4'hf, 15);
    wait_drain();
    finish_test("watchdog");

    // All credits home before they are withheld
    while (owed != 0)
      @(posedge PCLK);
    repeat (4) @(posedge PCLK);
    drop_before = drop_count;
    withhold    = 1'b1;
    for (int i = 0; i < CREDIT_MAX + QUEUE_DEPTH + 2; i++)
    begin
      addr = 32'h0000_9000 + 32'(i * 16);
      if (i < CREDIT_MAX + QUEUE_DEPTH)
        expect_report(RULE_PSTRB_READ, addr);
      run_transfer(addr, 1'b0, 4'hf, 0);
    end
    repeat (8) @(posedge PCLK);
    assert (drop_count == drop_before + DROP_COUNT_WIDTH'(2)) else
    begin
      errors++;
      $display("MISMATCH drop_count: expected %h, got %h",
               drop_before + DROP_COUNT_WIDTH'(2), drop_count);
    end
    withhold = 1'b0;
    wait_drain();
    finish_test("credits and overflow");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: apb_monitor_sva.sv
/*
 * Concurrent assertions for the APB4 monitor
 *  - reset state of the report outputs
 *  - outstanding reports within the credit grant
 *  - watchdog payload
 */
`timescale 1ns/1ns

module apb_monitor_sva
(
  input logic                                     PCLK,
  input logic                                     PRESETn,
  input logic                                     report_valid,
  input logic                                     report_credit,
  input logic [apb_mon_pkg::RULE_ID_WIDTH-1:0]    report_rule,
  input logic [apb_mon_pkg::PAYLOAD_WIDTH-1:0]    report_payload,
  input apb_mon_pkg::rule_vec_t                   violation_flags,
  input logic [apb_mon_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);
  import apb_mon_pkg::*;

  // Reports sent minus credits returned
  int outstanding;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(report_valid) - int'(report_credit);
  end

  ////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////
  reset_state_a: assert property (@(posedge PCLK)
    !PRESETn |=> (!report_valid && violation_flags == '0 && drop_count == '0))
    else $error("report outputs not cleared by reset");

  credit_bound_a: assert property (@(posedge PCLK) disable iff (!PRESETn)
    outstanding <= CREDIT_MAX)
    else $error("more reports outstanding than credits granted");

  // Watchdog view: wait count in the low bits, zeros above
  wdog_payload_a: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (report_valid && report_rule == RULE_ID_WIDTH'(RULE_WATCHDOG))
      |-> report_payload == PAYLOAD_WIDTH'(WATCHDOG_LIMIT))
    else $error("watchdog report payload differs from the limit");

endmodule

bind apb_monitor_top apb_monitor_sva apb_monitor_sva_i (
  .PCLK            (PCLK),
  .PRESETn         (PRESETn),
  .report_valid    (report_valid),
  .report_credit   (report_credit),
  .report_rule     (report_rule),
  .report_payload  (report_payload),
  .violation_flags (violation_flags),
  .drop_count      (drop_count)
);

// File: apb_monitor_top.sv
/*
 * APB4 protocol monitor top level
 *  - capture, rule and report stages
 *  - plain APB4 and report ports
 */
`timescale 1ns/1ns

module apb_monitor_top
(
  input  logic                                     PCLK,
  input  logic                                     PRESETn,
  input  logic                                     psel,
  input  logic                                     penable,
  input  logic [apb_mon_pkg::ADDR_WIDTH-1:0]       paddr,
  input  logic                                     pwrite,
  input  logic [apb_mon_pkg::DATA_WIDTH-1:0]       pwdata,
  input  logic [apb_mon_pkg::STRB_WIDTH-1:0]       pstrb,
  input  logic [apb_mon_pkg::PROT_WIDTH-1:0]       pprot,
  input  logic                                     pready,
  input  logic                                     report_credit,
  output logic                                     report_valid,
  output logic [apb_mon_pkg::RULE_ID_WIDTH-1:0]    report_rule,
  output logic [apb_mon_pkg::PAYLOAD_WIDTH-1:0]    report_payload,
  output apb_mon_pkg::rule_vec_t                   violation_flags,
  output logic [apb_mon_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);
  import apb_mon_pkg::*;

  rule_vec_t                   viol_vec;
  logic [ADDR_WIDTH-1:0]       viol_addr;
  logic [WAIT_COUNT_WIDTH-1:0] wait_count;

  // Snapshot between stage 1 and stage 2
  apb_mon_if snap_if ();

  apb_capture_stage apb_capture_stage_i (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pprot   (pprot),
    .pready  (pready),
    .snap    (snap_if.capture_mp)
  );

  apb_rule_stage apb_rule_stage_i (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .snap       (snap_if.rule_mp),
    .viol_vec   (viol_vec),
    .viol_addr  (viol_addr),
    .wait_count (wait_count)
  );

  apb_report_queue apb_report_queue_i (
    .PCLK            (PCLK),
    .PRESETn         (PRESETn),
    .viol_vec        (viol_vec),
    .viol_addr       (viol_addr),
    .wait_count      (wait_count),
    .report_credit   (report_credit),
    .report_valid    (report_valid),
    .report_rule     (report_rule),
    .report_payload  (report_payload),
    .violation_flags (violation_flags),
    .drop_count      (drop_count)
  );

endmodule

// File: apb_report_queue.sv
/*
 * Stage 3 of the APB4 monitor
 *  - lowest-rule select and payload build
 *  - report FIFO with credit-based output
 *  - sticky violation flags and saturating drop counter
 */
`timescale 1ns/1ns

module apb_report_queue
(
  input  logic                                     PCLK,
  input  logic                                     PRESETn,
  input  apb_mon_pkg::rule_vec_t                   viol_vec,
  input  logic [apb_mon_pkg::ADDR_WIDTH-1:0]       viol_addr,
  input  logic [apb_mon_pkg::WAIT_COUNT_WIDTH-1:0] wait_count,
  input  logic                                     report_credit,
  output logic                                     report_valid,
  output logic [apb_mon_pkg::RULE_ID_WIDTH-1:0]    report_rule,
  output apb_mon_pkg::report_payload_u             report_payload,
  output apb_mon_pkg::rule_vec_t                   violation_flags,
  output logic [apb_mon_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);
  import apb_mon_pkg::*;

  logic [RULE_ID_WIDTH-1:0] mem_rule [QUEUE_DEPTH];
  report_payload_u          mem_payload [QUEUE_DEPTH];
  logic [QPTR_WIDTH-1:0]    wr_ptr;
  logic [QPTR_WIDTH-1:0]    rd_ptr;
  logic [QCNT_WIDTH-1:0]    q_count;
  logic [CREDIT_WIDTH-1:0]  credits;
  logic [RULE_ID_WIDTH-1:0] new_rule;
  report_payload_u          new_payload;
  logic                     push;
  logic                     pop;
  logic                     drop;

  // Priority encoder, bit 0 wins
  function automatic logic [RULE_ID_WIDTH-1:0] lowest_rule(input rule_vec_t v);
    logic [RULE_ID_WIDTH-1:0] id;
    id = '0;
    for (int i = NUM_RULES - 1; i >= 0; i--)
      if (v[i])
        id = RULE_ID_WIDTH'(i);
    return id;
  endfunction

  function automatic logic [QPTR_WIDTH-1:0] next_ptr(input logic [QPTR_WIDTH-1:0] p);
    return (p == QPTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // New report
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    new_rule    = lowest_rule(viol_vec);
    new_payload = '0;
    if (new_rule == RULE_ID_WIDTH'(RULE_WATCHDOG))
      new_payload.wdog.cycles = wait_count;
    else
      new_payload.addr = viol_addr;
  end

  assign push = (|viol_vec) & (q_count != QCNT_WIDTH'(QUEUE_DEPTH));
  assign drop = (|viol_vec) & ~push;
  // One report per clock while credits last
  assign pop  = (q_count != '0) & (credits != '0);

  ////////////////////////////////////////////////////////////
  // Queue control, credits, flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      q_count         <= '0;
      credits         <= CREDIT_WIDTH'(CREDIT_MAX);
      report_valid    <= 1'b0;
      violation_flags <= '0;
      drop_count      <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      q_count <= q_count + QCNT_WIDTH'(push) - QCNT_WIDTH'(pop);

      // Spend on send, refill on credit pulse, never above the grant
      case ({pop, report_credit})
        2'b10: credits <= credits - 1'b1;
        2'b01:
          if (credits != CREDIT_WIDTH'(CREDIT_MAX))
            credits <= credits + 1'b1;
        default: ;
      endcase

      report_valid    <= pop;
      violation_flags <= violation_flags | viol_vec;
      if (drop && !(&drop_count))
        drop_count <= drop_count + 1'b1;
    end
  end

  // FIFO storage and output word
  always_ff @(posedge PCLK)
  begin
    if (push)
    begin
      mem_rule[wr_ptr]    <= new_rule;
      mem_payload[wr_ptr] <= new_payload;
    end
    if (pop)
    begin
      report_rule    <= mem_rule[rd_ptr];
      report_payload <= mem_payload[rd_ptr];
    end
  end

endmodule

// File: apb_rule_stage.sv
/*
 * Stage 2 of the APB4 monitor
 *  - phase, stability, strobe and alignment rules on each snapshot
 *  - transfer watchdog
 *  - registered violation vector with address and wait count
 */
`timescale 1ns/1ns

module apb_rule_stage
(
  input  logic                                     PCLK,
  input  logic                                     PRESETn,
  apb_mon_if.rule_mp                               snap,
  output apb_mon_pkg::rule_vec_t                   viol_vec,
  output logic [apb_mon_pkg::ADDR_WIDTH-1:0]       viol_addr,
  output logic [apb_mon_pkg::WAIT_COUNT_WIDTH-1:0] wait_count
);
  import apb_mon_pkg::*;

  rule_vec_t                   hit;
  logic                        stable_chk;
  logic                        wr_setup;
  logic                        strb_ok;
  logic [WORD_LSB-1:0]         align_mask;
  logic                        wd_run;
  logic                        wd_hit;
  logic [WAIT_COUNT_WIDTH-1:0] wd_cnt;
  logic [WAIT_COUNT_WIDTH-1:0] wd_next;

  ////////////////////////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////////////////////////
  // Match against every naturally aligned byte/half-word/word group
  // align_mask keeps the address bits that must be zero for that size
  always_comb
  begin
    strb_ok    = 1'b0;
    align_mask = '0;
    for (int s = 0; s <= WORD_LSB; s++)
      for (int o = 0; o < STRB_WIDTH; o += (1 << s))
        if (snap.pstrb == STRB_WIDTH'(((1 << (1 << s)) - 1) << o))
        begin
          strb_ok    = 1'b1;
          align_mask = WORD_LSB'((1 << s) - 1);
        end
  end

  // Stability only inside a transfer that is still waiting
  assign stable_chk = snap.snap_valid & snap.prev_psel & ~snap.prev_pready;

  // Attribute rules are checked once per transfer, in Setup
  // Later changes are caught by the stability rules
  assign wr_setup   = snap.setup_phase & snap.pwrite;

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////
  // Runs while selected and not completing
  assign wd_run  = snap.snap_valid & ~(snap.penable & snap.pready);
  assign wd_next = wd_cnt + 1'b1;
  assign wd_hit  = wd_run & (wd_next == WAIT_COUNT_WIDTH'(WATCHDOG_LIMIT));

  ////////////////////////////////////////////////////////////
  // Rule evaluation
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    hit = '0;
    // PSEL gone while an Access was still pending
    hit[RULE_PSEL_DROP]        = ~snap.snap_valid & snap.access_phase;
    hit[RULE_PENABLE_SETUP]    = snap.setup_phase & snap.penable;
    hit[RULE_PENABLE_ACCESS]   = snap.access_phase & snap.snap_valid & ~snap.penable;
    hit[RULE_PADDR_UNSTABLE]   = stable_chk & (snap.paddr != snap.prev_paddr);
    hit[RULE_PWRITE_UNSTABLE]  = stable_chk & (snap.pwrite != snap.prev_pwrite);
    hit[RULE_PWDATA_UNSTABLE]  = stable_chk & (snap.pwdata != snap.prev_pwdata);
    hit[RULE_PSTRB_UNSTABLE]   = stable_chk & (snap.pstrb != snap.prev_pstrb);
    hit[RULE_PPROT_UNSTABLE]   = stable_chk & (snap.pprot != snap.prev_pprot);
    // All-zero strobe on a write is legal
    hit[RULE_PSTRB_SHAPE]      = wr_setup & (|snap.pstrb) & ~strb_ok;
    hit[RULE_PSTRB_READ]       = snap.setup_phase & ~snap.pwrite & (|snap.pstrb);
    hit[RULE_PADDR_STRB_ALIGN] = wr_setup & strb_ok &
                                 (|(snap.paddr[WORD_LSB-1:0] & align_mask));
    hit[RULE_PADDR_WORD_ALIGN] = snap.setup_phase & (|snap.paddr[WORD_LSB-1:0]);
    hit[RULE_WATCHDOG]         = wd_hit;
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      viol_vec <= '0;
      wd_cnt   <= '0;
    end
    else
    begin
      viol_vec <= hit;
      // Restart after firing so a long stall reports again
      wd_cnt   <= (wd_run && !wd_hit) ? wd_next : '0;
    end
  end

  // Report fields, valid with viol_vec
  // PSEL already low on a drop, so take the address of the cycle before
  always_ff @(posedge PCLK)
  begin
    viol_addr  <= snap.snap_valid ? snap.paddr : snap.prev_paddr;
    wait_count <= wd_next;
  end

endmodule

// File: apb_capture_stage.sv
/*
 * Stage 1 of the APB4 monitor
 *  - registers the bus every clock
 *  - keeps the previous-cycle copy
 *  - tracks the Setup and Access phases
 */
`timescale 1ns/1ns

module apb_capture_stage
(
  input  logic                               PCLK,
  input  logic                               PRESETn,
  input  logic                               psel,
  input  logic                               penable,
  input  logic [apb_mon_pkg::ADDR_WIDTH-1:0] paddr,
  input  logic                               pwrite,
  input  logic [apb_mon_pkg::DATA_WIDTH-1:0] pwdata,
  input  logic [apb_mon_pkg::STRB_WIDTH-1:0] pstrb,
  input  logic [apb_mon_pkg::PROT_WIDTH-1:0] pprot,
  input  logic                               pready,
  apb_mon_if.capture_mp                      snap
);

  // Only needed to spot a completed Access
  logic prev_penable;

  ////////////////////////////////////////////////////////////
  // Control samples
  ////////////////////////////////////////////////////////////
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      snap.snap_valid  <= 1'b0;
      snap.penable     <= 1'b0;
      snap.pready      <= 1'b0;
      snap.prev_psel   <= 1'b0;
      snap.prev_pready <= 1'b0;
      prev_penable     <= 1'b0;
    end
    else
    begin
      snap.snap_valid  <= psel;
      snap.penable     <= penable;
      snap.pready      <= pready;
      snap.prev_psel   <= snap.snap_valid;
      snap.prev_pready <= snap.pready;
      prev_penable     <= snap.penable;
    end
  end

  // Address and data samples
  always_ff @(posedge PCLK)
  begin
    snap.paddr       <= paddr;
    snap.pwrite      <= pwrite;
    snap.pwdata      <= pwdata;
    snap.pstrb       <= pstrb;
    snap.pprot       <= pprot;
    snap.prev_paddr  <= snap.paddr;
    snap.prev_pwrite <= snap.pwrite;
    snap.prev_pwdata <= snap.pwdata;
    snap.prev_pstrb  <= snap.pstrb;
    snap.prev_pprot  <= snap.pprot;
  end

  ////////////////////////////////////////////////////////////
  // Phase tracking
  ////////////////////////////////////////////////////////////
  // Setup: PSEL rising, or PSEL held after a completed Access
  assign snap.setup_phase = snap.snap_valid &
                            (~snap.prev_psel | (prev_penable & snap.prev_pready));

  // Access follows Setup, ends on PREADY or when PSEL goes away
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      snap.access_phase <= 1'b0;
    else if (snap.setup_phase)
      snap.access_phase <= 1'b1;
    else if (snap.pready || !snap.snap_valid)
      snap.access_phase <= 1'b0;
  end

endmodule

// File: apb_mon_if.sv
/*
 * Bus snapshot from the capture stage to the rule stage
 *  - current and previous-cycle APB4 signals
 *  - Setup/Access phase flags
 */
`timescale 1ns/1ns

interface apb_mon_if;
  import apb_mon_pkg::*;

  // Current sample, snap_valid is the registered PSEL
  logic                  snap_valid;
  logic                  penable;
  logic [ADDR_WIDTH-1:0] paddr;
  logic                  pwrite;
  logic [DATA_WIDTH-1:0] pwdata;
  logic [STRB_WIDTH-1:0] pstrb;
  logic [PROT_WIDTH-1:0] pprot;
  logic                  pready;

  // Sample from one cycle earlier
  logic                  prev_psel;
  logic                  prev_pready;
  logic [ADDR_WIDTH-1:0] prev_paddr;
  logic                  prev_pwrite;
  logic [DATA_WIDTH-1:0] prev_pwdata;
  logic [STRB_WIDTH-1:0] prev_pstrb;
  logic [PROT_WIDTH-1:0] prev_pprot;

  logic                  setup_phase;
  logic                  access_phase;

  modport capture_mp (
    output snap_valid, penable, paddr, pwrite, pwdata, pstrb, pprot, pready,
    output prev_psel, prev_pready, prev_paddr, prev_pwrite, prev_pwdata,
    output prev_pstrb, prev_pprot, setup_phase, access_phase
  );

  modport rule_mp (
    input snap_valid, penable, paddr, pwrite, pwdata, pstrb, pprot, pready,
    input prev_psel, prev_pready, prev_paddr, prev_pwrite, prev_pwdata,
    input prev_pstrb, prev_pprot, setup_phase, access_phase
  );

endinterface

// File: apb_mon_pkg.sv
/*
 * Shared definitions for the APB4 protocol monitor
 *  - bus widths and word offset bits
 *  - rule numbers and the rule vector type
 *  - watchdog limit, credit and queue limits, counter widths
 *  - report payload union (address view or watchdog view)
 */
package apb_mon_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////
  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int STRB_WIDTH    = DATA_WIDTH / 8;
  localparam int PROT_WIDTH    = 3;
  // Address bits below one data word
  localparam int WORD_LSB      = $clog2(STRB_WIDTH);
  localparam int PAYLOAD_WIDTH = ADDR_WIDTH;

  ////////////////////////////////////////////////////////////
  // Rule numbering
  ////////////////////////////////////////////////////////////
  localparam int NUM_RULES     = 13;
  localparam int RULE_ID_WIDTH = $clog2(NUM_RULES);

  // Lower number wins when several rules fire together
  localparam int RULE_PSEL_DROP        = 0;
  localparam int RULE_PENABLE_SETUP    = 1;
  localparam int RULE_PENABLE_ACCESS   = 2;
  localparam int RULE_PADDR_UNSTABLE   = 3;
  localparam int RULE_PWRITE_UNSTABLE  = 4;
  localparam int RULE_PWDATA_UNSTABLE  = 5;
  localparam int RULE_PSTRB_UNSTABLE   = 6;
  localparam int RULE_PPROT_UNSTABLE   = 7;
  localparam int RULE_PSTRB_SHAPE      = 8;
  localparam int RULE_PSTRB_READ       = 9;
  localparam int RULE_PADDR_STRB_ALIGN = 10;
  localparam int RULE_PADDR_WORD_ALIGN = 11;
  localparam int RULE_WATCHDOG         = 12;

  typedef logic [NUM_RULES-1:0] rule_vec_t;

  ////////////////////////////////////////////////////////////
  // Watchdog, credits, report queue
  ////////////////////////////////////////////////////////////
  localparam int WATCHDOG_LIMIT   = 16;
  localparam int WAIT_COUNT_WIDTH = 8;
  localparam int CREDIT_MAX       = 4;
  localparam int CREDIT_WIDTH     = $clog2(CREDIT_MAX + 1);
  localparam int QUEUE_DEPTH      = 4;
  localparam int QPTR_WIDTH       = $clog2(QUEUE_DEPTH);
  localparam int QCNT_WIDTH       = $clog2(QUEUE_DEPTH + 1);
  localparam int DROP_COUNT_WIDTH = 8;

  // Report word, decoded by rule number
  // Watchdog report holds the wait count, upper bits zero
  typedef union packed {
    logic [PAYLOAD_WIDTH-1:0] addr;
    struct packed {
      logic [PAYLOAD_WIDTH-WAIT_COUNT_WIDTH-1:0] pad;
      logic [WAIT_COUNT_WIDTH-1:0]               cycles;
    } wdog;
  } report_payload_u;

endpackage
